/* bench/cic_stim.txt */
# in channel count gap i q : count strobes of hex samples i q, gap cycles apart
# exp channel i q : next rounded output of the channel, hex
# ch0 impulse on I and Q, then zeros, then a small DC step
in 0 1 8 7fff 8000
in 0 31 8 0000 0000
in 0 16 8 0200 fe00
# ch1 full scale negative DC on I, small DC on Q, runs alongside ch0
in 1 32 8 8000 0123
exp 0 0540 fac0
exp 0 0a80 f580
exp 0 0040 ffc0
exp 0 0000 0000
exp 0 0038 ffc8
exp 0 0188 fe78
exp 1 f200 0020
exp 1 9e00 00df
exp 1 8000 0123
exp 1 8000 0123

/* bench/tb_cic_rx.sv */
// testbench top for the two-channel cic decimator
// file driven stimulus per channel, ordered output checks, watchdog
`default_nettype none

module tb_cic_rx
	import cic_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DRIVE_DELAY = 5;
	localparam int MAX_RECORDS = 64;
	localparam int RESET_CYCLES = 10;
	// quiet cycles after the last output
	localparam int IDLE_TAIL = 100;
	localparam int WATCH_PER_OUTPUT = 200;
	localparam logic [31:0] SEED = 32'h830fce00;

	logic clock;
	logic rst;
	logic [NUM_CHANNELS-1:0] in_strobe;
	in_sample_t in_data_i [NUM_CHANNELS];
	in_sample_t in_data_q [NUM_CHANNELS];
	logic [NUM_CHANNELS-1:0] out_strobe_i;
	logic [NUM_CHANNELS-1:0] out_strobe_q;
	out_sample_t out_data [NUM_CHANNELS];

	// input records, count strobes each with the same gap
	int rec_chan [MAX_RECORDS];
	int rec_count [MAX_RECORDS];
	int rec_gap [MAX_RECORDS];
	in_sample_t rec_i [MAX_RECORDS];
	in_sample_t rec_q [MAX_RECORDS];
	int num_records;
	// expected outputs per channel, in order
	out_sample_t exp_i [NUM_CHANNELS][MAX_RECORDS];
	out_sample_t exp_q [NUM_CHANNELS][MAX_RECORDS];
	int exp_count [NUM_CHANNELS];
	int exp_pos [NUM_CHANNELS];
	int in_count [NUM_CHANNELS];
	logic q_pending [NUM_CHANNELS];
	int outputs_left;
	int error_count;
	int watchdog_cycles;
	logic stim_loaded;

	tb_clock_gen u_clock (.clock_o(clock), .rst_o(rst));

	cic_rx_top DUT (
		.clock(clock), .rst_i(rst),
		.ch0_in_strobe_i(in_strobe[0]), .ch0_in_data_i_i(in_data_i[0]),
		.ch0_in_data_q_i(in_data_q[0]), .ch0_out_strobe_i_o(out_strobe_i[0]),
		.ch0_out_strobe_q_o(out_strobe_q[0]), .ch0_out_data_o(out_data[0]),
		.ch1_in_strobe_i(in_strobe[1]), .ch1_in_data_i_i(in_data_i[1]),
		.ch1_in_data_q_i(in_data_q[1]), .ch1_out_strobe_i_o(out_strobe_i[1]),
		.ch1_out_strobe_q_o(out_strobe_q[1]), .ch1_out_data_o(out_data[1])
	);

	// ------------------------------
	// failure reporting
	task automatic abort_run(input string reason);
		$display("ERROR at %0d ns: %s", $time, reason);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input out_sample_t got,
		input out_sample_t expected);
		if (got !== expected)
		begin
			error_count++;
			$display("FAIL at %0d ns: %s = %h, expected %h", $time, name, got, expected);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	// ------------------------------
	// stimulus file, "#" lines are comments
	task automatic load_stimulus();
		int fd;
		int code;
		int ch;
		int cnt;
		int gap;
		logic [15:0] val_i;
		logic [15:0] val_q;
		logic [63:0] kind;
		logic [8*160-1:0] rest;
		logic at_end;
		fd = $fopen("bench/cic_stim.txt", "r");
		if (fd == 0)
			abort_run("cannot open the stimulus file bench/cic_stim.txt");
		else
		begin
			// reset and memory clear sweep come first
			watchdog_cycles = RESET_CYCLES + RAM_DEPTH;
			at_end = 1'b0;
			while (!at_end)
			begin
				kind = '0;
				code = $fscanf(fd, "%s", kind);
				if (code != 1)
					at_end = 1'b1;
				else if (kind == "#")
					code = $fgets(rest, fd);
				else if (kind == "in")
				begin
					code = $fscanf(fd, "%d %d %d %h %h", ch, cnt, gap, val_i, val_q);
					if (code != 5 || ch < 0 || ch >= NUM_CHANNELS || num_records >= MAX_RECORDS)
						abort_run("malformed input record in the stimulus file");
					else if (gap < MIN_STROBE_GAP)
						abort_run("input gap below the minimum strobe spacing");
					else
					begin
						rec_chan[num_records] = ch;
						rec_count[num_records] = cnt;
						rec_gap[num_records] = gap;
						rec_i[num_records] = val_i;
						rec_q[num_records] = val_q;
						num_records++;
						watchdog_cycles += cnt * gap;
					end
				end
				else if (kind == "exp")
				begin
					code = $fscanf(fd, "%d %h %h", ch, val_i, val_q);
					if (code != 3 || ch < 0 || ch >= NUM_CHANNELS || exp_count[ch] >= MAX_RECORDS)
						abort_run("malformed expected record in the stimulus file");
					else
					begin
						exp_i[ch][exp_count[ch]] = val_i;
						exp_q[ch][exp_count[ch]] = val_q;
						exp_count[ch]++;
						outputs_left++;
						watchdog_cycles += WATCH_PER_OUTPUT;
					end
				end
				else
					abort_run("unknown record kind in the stimulus file");
			end
			$fclose(fd);
		end
	endtask

	// ------------------------------
	// driver, inputs change just after the rising edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clock);
		#DRIVE_DELAY;
	endtask

	task automatic drive_channel(input int ch);
		int extra;
		for (int r = 0; r < num_records; r++)
		begin
			if (rec_chan[r] == ch)
			begin
				for (int n = 0; n < rec_count[r]; n++)
				begin
					// jitter on top of the record gap
					extra = $urandom % 4;
					in_strobe[ch] = 1'b1;
					in_data_i[ch] = rec_i[r];
					in_data_q[ch] = rec_q[r];
					in_count[ch]++;
					wait_cycles(1);
					in_strobe[ch] = 1'b0;
					in_data_i[ch] = '0;
					in_data_q[ch] = '0;
					wait_cycles(rec_gap[r] - 1 + extra);
				end
			end
		end
	endtask

	// ------------------------------
	// checker, I word then Q word per decimated output
	task automatic check_channel(input int ch);
		string name;
		if (out_strobe_i[ch] && out_strobe_q[ch])
			abort_run($sformatf("channel %0d raised both output strobes together", ch));
		else if (out_strobe_i[ch])
		begin
			name = $sformatf("ch%0d_out_data_o I, output %0d", ch, exp_pos[ch]);
			if (exp_pos[ch] >= exp_count[ch])
				abort_run($sformatf("channel %0d gave an output that was not expected", ch));
			else if (in_count[ch] < DECIMATION * (exp_pos[ch] + 1))
				abort_run($sformatf("channel %0d gave an output before a full block", ch));
			else if (q_pending[ch])
				abort_run($sformatf("channel %0d gave a second I word before Q", ch));
			else
			begin
				check_value(name, out_data[ch], exp_i[ch][exp_pos[ch]]);
				q_pending[ch] = 1'b1;
			end
		end
		else if (out_strobe_q[ch])
		begin
			name = $sformatf("ch%0d_out_data_o Q, output %0d", ch, exp_pos[ch]);
			if (!q_pending[ch])
				abort_run($sformatf("channel %0d gave a Q word without an I word", ch));
			else
			begin
				check_value(name, out_data[ch], exp_q[ch][exp_pos[ch]]);
				q_pending[ch] = 1'b0;
				exp_pos[ch]++;
				outputs_left--;
			end
		end
	endtask

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clock)
	begin
		if (stim_loaded === 1'b1 && rst === 1'b0)
		begin
			for (int ch = 0; ch < NUM_CHANNELS; ch++)
				check_channel(ch);
		end
	end

	// ------------------------------
	// watchdog sized from the stimulus
	initial
	begin
		wait (stim_loaded === 1'b1);
		repeat (watchdog_cycles) @(posedge clock);
		abort_run($sformatf("watchdog expired after %0d cycles, outputs stopped arriving",
			watchdog_cycles));
	end

	// ------------------------------
	// main sequence
	initial
	begin
		in_strobe = '0;
		for (int ch = 0; ch < NUM_CHANNELS; ch++)
		begin
			in_data_i[ch] = '0;
			in_data_q[ch] = '0;
			exp_count[ch] = 0;
			exp_pos[ch] = 0;
			in_count[ch] = 0;
			q_pending[ch] = 1'b0;
		end
		num_records = 0;
		outputs_left = 0;
		error_count = 0;
		watchdog_cycles = 0;
		stim_loaded = 1'b0;
		void'($urandom(SEED));
		load_stimulus();
		stim_loaded = 1'b1;
		wait (rst === 1'b0);
		// memory clear sweep holds all grants
		wait_cycles(RAM_DEPTH);
		// both channels together so the comb passes contend
		fork
			drive_channel(0);
			drive_channel(1);
		join
		wait (outputs_left == 0);
		wait_cycles(IDLE_TAIL);
		if (error_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
// clock and reset source for the cic testbench
`default_nettype none

module tb_clock_gen
(
	output logic clock_o,
	output logic rst_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// 40 ns period
	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 10;
	localparam int DRIVE_DELAY = 5;

	initial
	begin
		clock_o = 1'b0;
		forever
			#HALF_PERIOD clock_o = ~clock_o;
	end

	// reset held for RESET_CYCLES rising edges
	initial
	begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock_o);
		#DRIVE_DELAY rst_o = 1'b0;
	end

endmodule

`default_nettype wire

/* logic/cic_comb_sequencer.sv */
// sequential comb section for one channel, runs the comb stages
// against the shared state memory and rounds the i and q results
`default_nettype none

module cic_comb_sequencer
	import cic_pkg::*;
#(
	parameter int unsigned CHANNEL = 0
)
(
	input  wire         clock,
	input  wire         rst_i,
	input  wire         comb_start_i,
	input  wire acc_t   integ_i_i,
	input  wire acc_t   integ_q_i,
	output logic        mem_req_o,
	output logic        mem_we_o,
	output ram_addr_t   mem_addr_o,
	output acc_t        mem_wdata_o,
	input  wire         mem_gnt_i,
	input  wire acc_t   mem_rdata_i,
	output logic        out_strobe_i_o,
	output logic        out_strobe_q_o,
	output out_sample_t out_data_o
);

	comb_state_t state;
	// current comb stage, 1..STAGES during the stage loop
	stage_t stage;
	// 0 while working on i, 1 on q
	logic q_sel;
	logic chan_bit;
	logic access_done;
	// read data arrived this cycle
	logic rd_valid;
	acc_t rd_hold;
	acc_t rd_last;
	// comb s-1 of the current stage
	acc_t t_comb;
	acc_t diff;
	acc_t integ_i_reg;
	acc_t integ_q_reg;
	out_sample_t rounded;

	assign chan_bit = CHANNEL[0];
	assign access_done = mem_req_o & mem_gnt_i;

	// latest read word, held until the next own read returns
	assign rd_last = rd_valid ? mem_rdata_i : rd_hold;

	// comb[s] = comb[s-1] - prev[s], wraps like the integrators
	assign diff = t_comb - rd_last;

	// top OUT_WIDTH bits plus the next lower bit, wrapping
	assign rounded = rd_last[ACC_WIDTH-1 -: OUT_WIDTH]
		+ {{(OUT_WIDTH-1){1'b0}}, rd_last[ACC_WIDTH-1-OUT_WIDTH]};

	// ------------------------------
	// memory request decode
	// fields depend only on state and registers, so they hold until grant
	always_comb
	begin
		mem_req_o = 1'b0;
		mem_we_o = 1'b0;
		mem_addr_o = ram_addr(chan_bit, q_sel, KIND_COMB, stage);
		mem_wdata_o = t_comb;
		case (state)
			SEQ_LOAD:
			begin
				// comb[0] = integrator output
				mem_req_o = 1'b1;
				mem_we_o = 1'b1;
				mem_addr_o = ram_addr(chan_bit, q_sel, KIND_COMB, '0);
				mem_wdata_o = q_sel ? integ_q_reg : integ_i_reg;
			end
			SEQ_READ_COMB:
			begin
				mem_req_o = 1'b1;
				mem_addr_o = ram_addr(chan_bit, q_sel, KIND_COMB, stage_t'(stage - 1'b1));
			end
			SEQ_READ_PREV:
			begin
				mem_req_o = 1'b1;
				mem_addr_o = ram_addr(chan_bit, q_sel, KIND_PREV, stage);
			end
			SEQ_WRITE_COMB:
			begin
				mem_req_o = 1'b1;
				mem_we_o = 1'b1;
				mem_addr_o = ram_addr(chan_bit, q_sel, KIND_COMB, stage);
				mem_wdata_o = diff;
			end
			SEQ_WRITE_PREV:
			begin
				// old comb[s-1] becomes the delay line of stage s
				mem_req_o = 1'b1;
				mem_we_o = 1'b1;
				mem_addr_o = ram_addr(chan_bit, q_sel, KIND_PREV, stage);
				mem_wdata_o = t_comb;
			end
			SEQ_READ_LAST:
			begin
				mem_req_o = 1'b1;
				mem_addr_o = ram_addr(chan_bit, q_sel, KIND_COMB, stage_t'(STAGES));
			end
			default:
			begin
				mem_req_o = 1'b0;
			end
		endcase
	end

	// ------------------------------
	// control fsm
	always_ff @(posedge clock)
	begin
		if (rst_i)
		begin
			state <= SEQ_IDLE;
			stage <= '0;
			q_sel <= 1'b0;
			rd_valid <= 1'b0;
			out_strobe_i_o <= 1'b0;
			out_strobe_q_o <= 1'b0;
		end
		else
		begin
			// read data shows up one cycle after a granted read
			rd_valid <= access_done & ~mem_we_o;
			out_strobe_i_o <= 1'b0;
			out_strobe_q_o <= 1'b0;
			case (state)
				SEQ_IDLE:
					if (comb_start_i)
					begin
						q_sel <= 1'b0;
						state <= SEQ_LOAD;
					end
				SEQ_LOAD:
					if (access_done)
					begin
						stage <= stage_t'(1);
						state <= SEQ_READ_COMB;
					end
				SEQ_READ_COMB:
					if (access_done)
						state <= SEQ_READ_PREV;
				SEQ_READ_PREV:
					if (access_done)
						state <= SEQ_WRITE_COMB;
				SEQ_WRITE_COMB:
					if (access_done)
						state <= SEQ_WRITE_PREV;
				SEQ_WRITE_PREV:
					if (access_done)
					begin
						if (stage == stage_t'(STAGES))
							state <= SEQ_READ_LAST;
						else
						begin
							stage <= stage + 1'b1;
							state <= SEQ_READ_COMB;
						end
					end
				SEQ_READ_LAST:
					if (access_done)
						state <= SEQ_OUTPUT;
				SEQ_OUTPUT:
				begin
					// i result first, then loop back for q
					out_strobe_i_o <= ~q_sel;
					out_strobe_q_o <= q_sel;
					q_sel <= ~q_sel;
					state <= q_sel ? SEQ_IDLE : SEQ_LOAD;
				end
				default:
					state <= SEQ_IDLE;
			endcase
		end
	end

	// ------------------------------
	// data registers
	always_ff @(posedge clock)
	begin
		if (comb_start_i && state == SEQ_IDLE)
		begin
			integ_i_reg <= integ_i_i;
			integ_q_reg <= integ_q_i;
		end
		if (rd_valid)
			rd_hold <= mem_rdata_i;
		// comb[s-1] is the latest read when prev[s] is granted
		if (state == SEQ_READ_PREV && access_done)
			t_comb <= rd_last;
		if (state == SEQ_OUTPUT)
			out_data_o <= rounded;
	end

endmodule

`default_nettype wire

/* logic/cic_integrator_chain.sv */
// cascaded i and q integrators at the input rate
// with the decimation counter that requests a comb pass
`default_nettype none

module cic_integrator_chain
	import cic_pkg::*;
(
	input  wire        clock,
	input  wire        rst_i,
	input  wire        in_strobe_i,
	input  wire in_sample_t in_data_i_i,
	input  wire in_sample_t in_data_q_i,
	output logic       comb_start_o,
	output acc_t       integ_i_o,
	output acc_t       integ_q_o
);

	// integrator registers, index 0 takes the input
	acc_t acc_i [STAGES];
	acc_t acc_q [STAGES];
	acc_t ext_i;
	acc_t ext_q;
	logic [$clog2(DECIMATION)-1:0] sample_cnt;

	// sign extension to the accumulator width
	assign ext_i = {{GROWTH{in_data_i_i[IN_WIDTH-1]}}, in_data_i_i};
	assign ext_q = {{GROWTH{in_data_q_i[IN_WIDTH-1]}}, in_data_q_i};

	// ------------------------------
	// integrators, wrap mod 2^ACC_WIDTH
	always_ff @(posedge clock)
	begin
		if (rst_i)
		begin
			for (int s = 0; s < STAGES; s++)
			begin
				acc_i[s] <= '0;
				acc_q[s] <= '0;
			end
		end
		else if (in_strobe_i)
		begin
			acc_i[0] <= acc_i[0] + ext_i;
			acc_q[0] <= acc_q[0] + ext_q;
			// each stage adds the previous stage's old value
			for (int s = 1; s < STAGES; s++)
			begin
				acc_i[s] <= acc_i[s] + acc_i[s-1];
				acc_q[s] <= acc_q[s] + acc_q[s-1];
			end
		end
	end

	// ------------------------------
	// decimation counter
	always_ff @(posedge clock)
	begin
		if (rst_i)
		begin
			sample_cnt <= '0;
			comb_start_o <= 1'b0;
		end
		else
		begin
			comb_start_o <= 1'b0;
			if (in_strobe_i)
			begin
				if (sample_cnt == DECIMATION - 1)
				begin
					// last sample of the block, kick the comb
					sample_cnt <= '0;
					comb_start_o <= 1'b1;
				end
				else
					sample_cnt <= sample_cnt + 1'b1;
			end
		end
	end

	// last integrator feeds the comb section
	assign integ_i_o = acc_i[STAGES-1];
	assign integ_q_o = acc_q[STAGES-1];

endmodule

`default_nettype wire

/* logic/cic_pkg.sv */
// filter constants, comb memory address layout and vector types
// shared by the cic receiver decimator
`default_nettype none

package cic_pkg;

	// ------------------------------
	// filter shape
	localparam int STAGES = 3;
	localparam int DECIMATION = 8;
	localparam int IN_WIDTH = 16;
	localparam int OUT_WIDTH = 16;
	// bit growth is S * log2(R) for a unit differential delay
	localparam int GROWTH = STAGES * $clog2(DECIMATION);
	localparam int ACC_WIDTH = IN_WIDTH + GROWTH;

	// ------------------------------
	// channels and comb memory
	localparam int NUM_CHANNELS = 2;
	localparam int STAGE_BITS = 3;
	// channel, i/q select, kind, stage from the top bit down
	localparam int RAM_ADDR_BITS = $clog2(NUM_CHANNELS) + 2 + STAGE_BITS;
	localparam int RAM_DEPTH = 2 ** RAM_ADDR_BITS;
	localparam logic KIND_COMB = 1'b0;
	localparam logic KIND_PREV = 1'b1;

	// input pacing per channel, keeps the comb pass ahead of the next request
	localparam int MIN_STROBE_GAP = 8;

	// ------------------------------
	// vector types
	typedef logic signed [IN_WIDTH-1:0] in_sample_t;
	typedef logic signed [ACC_WIDTH-1:0] acc_t;
	typedef logic signed [OUT_WIDTH-1:0] out_sample_t;
	typedef logic [RAM_ADDR_BITS-1:0] ram_addr_t;
	typedef logic [STAGE_BITS-1:0] stage_t;

	// comb sequencer states
	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_LOAD,
		SEQ_READ_COMB,
		SEQ_READ_PREV,
		SEQ_WRITE_COMB,
		SEQ_WRITE_PREV,
		SEQ_READ_LAST,
		SEQ_OUTPUT
	} comb_state_t;

	// pack the address fields into one memory word address
	function automatic ram_addr_t ram_addr(logic chan, logic q_sel, logic kind, stage_t stage);
		return {chan, q_sel, kind, stage};
	endfunction

endpackage

`default_nettype wire

/* logic/cic_rx_top.sv */
// two-channel i/q cic decimator top, integrator chains and comb
// sequencers around one shared state memory and its arbiter
`default_nettype none

module cic_rx_top
	import cic_pkg::*;
(
	input  wire         clock,
	input  wire         rst_i,
	// channel 0
	input  wire         ch0_in_strobe_i,
	input  wire in_sample_t ch0_in_data_i_i,
	input  wire in_sample_t ch0_in_data_q_i,
	output logic        ch0_out_strobe_i_o,
	output logic        ch0_out_strobe_q_o,
	output out_sample_t ch0_out_data_o,
	// channel 1
	input  wire         ch1_in_strobe_i,
	input  wire in_sample_t ch1_in_data_i_i,
	input  wire in_sample_t ch1_in_data_q_i,
	output logic        ch1_out_strobe_i_o,
	output logic        ch1_out_strobe_q_o,
	output out_sample_t ch1_out_data_o
);

	// integrator to sequencer
	logic ch0_comb_start;
	logic ch1_comb_start;
	acc_t ch0_integ_i;
	acc_t ch0_integ_q;
	acc_t ch1_integ_i;
	acc_t ch1_integ_q;

	// sequencer to arbiter
	logic ch0_mem_req;
	logic ch0_mem_we;
	logic ch0_mem_gnt;
	ram_addr_t ch0_mem_addr;
	acc_t ch0_mem_wdata;
	logic ch1_mem_req;
	logic ch1_mem_we;
	logic ch1_mem_gnt;
	ram_addr_t ch1_mem_addr;
	acc_t ch1_mem_wdata;

	// memory port, read data goes to both sequencers
	logic ram_we;
	ram_addr_t ram_addr;
	acc_t ram_wdata;
	acc_t ram_rdata;

	// ------------------------------
	// channel 0
	cic_integrator_chain u_integ0 (
		.clock(clock), .rst_i(rst_i), .in_strobe_i(ch0_in_strobe_i),
		.in_data_i_i(ch0_in_data_i_i), .in_data_q_i(ch0_in_data_q_i),
		.comb_start_o(ch0_comb_start), .integ_i_o(ch0_integ_i), .integ_q_o(ch0_integ_q)
	);

	cic_comb_sequencer #(.CHANNEL(0)) u_comb0 (
		.clock(clock), .rst_i(rst_i), .comb_start_i(ch0_comb_start),
		.integ_i_i(ch0_integ_i), .integ_q_i(ch0_integ_q),
		.mem_req_o(ch0_mem_req), .mem_we_o(ch0_mem_we), .mem_addr_o(ch0_mem_addr),
		.mem_wdata_o(ch0_mem_wdata), .mem_gnt_i(ch0_mem_gnt), .mem_rdata_i(ram_rdata),
		.out_strobe_i_o(ch0_out_strobe_i_o), .out_strobe_q_o(ch0_out_strobe_q_o),
		.out_data_o(ch0_out_data_o)
	);

	// ------------------------------
	// channel 1
	cic_integrator_chain u_integ1 (
		.clock(clock), .rst_i(rst_i), .in_strobe_i(ch1_in_strobe_i),
		.in_data_i_i(ch1_in_data_i_i), .in_data_q_i(ch1_in_data_q_i),
		.comb_start_o(ch1_comb_start), .integ_i_o(ch1_integ_i), .integ_q_o(ch1_integ_q)
	);

	cic_comb_sequencer #(.CHANNEL(1)) u_comb1 (
		.clock(clock), .rst_i(rst_i), .comb_start_i(ch1_comb_start),
		.integ_i_i(ch1_integ_i), .integ_q_i(ch1_integ_q),
		.mem_req_o(ch1_mem_req), .mem_we_o(ch1_mem_we), .mem_addr_o(ch1_mem_addr),
		.mem_wdata_o(ch1_mem_wdata), .mem_gnt_i(ch1_mem_gnt), .mem_rdata_i(ram_rdata),
		.out_strobe_i_o(ch1_out_strobe_i_o), .out_strobe_q_o(ch1_out_strobe_q_o),
		.out_data_o(ch1_out_data_o)
	);

	// ------------------------------
	// shared comb memory
	comb_ram_arbiter u_arb (
		.clock(clock), .rst_i(rst_i),
		.req0_i(ch0_mem_req), .we0_i(ch0_mem_we), .addr0_i(ch0_mem_addr),
		.wdata0_i(ch0_mem_wdata), .gnt0_o(ch0_mem_gnt),
		.req1_i(ch1_mem_req), .we1_i(ch1_mem_we), .addr1_i(ch1_mem_addr),
		.wdata1_i(ch1_mem_wdata), .gnt1_o(ch1_mem_gnt),
		.ram_we_o(ram_we), .ram_addr_o(ram_addr), .ram_wdata_o(ram_wdata)
	);

	comb_ram u_ram (
		.clock(clock), .we_i(ram_we), .addr_i(ram_addr),
		.wdata_i(ram_wdata), .rdata_o(ram_rdata)
	);

endmodule

`default_nettype wire

/* logic/comb_ram.sv */
// comb state memory, single clock
// read-first with a registered read port
`default_nettype none

module comb_ram
	import cic_pkg::*;
(
	input  wire         clock,
	input  wire         we_i,
	input  wire ram_addr_t addr_i,
	input  wire acc_t   wdata_i,
	output acc_t        rdata_o
);

	// comb and prev words for both channels
	acc_t mem [RAM_DEPTH];

	// ------------------------------
	// one access per cycle
	always_ff @(posedge clock)
	begin
		// old contents come out on a write to the same word
		rdata_o <= mem[addr_i];
		if (we_i)
			mem[addr_i] <= wdata_i;
	end

endmodule

`default_nettype wire

/* logic/comb_ram_arbiter.sv */
// round-robin arbiter for the shared comb state memory
// sweeps zeros through the memory after reset
`default_nettype none

module comb_ram_arbiter
	import cic_pkg::*;
(
	input  wire         clock,
	input  wire         rst_i,
	input  wire         req0_i,
	input  wire         we0_i,
	input  wire ram_addr_t addr0_i,
	input  wire acc_t   wdata0_i,
	output logic        gnt0_o,
	input  wire         req1_i,
	input  wire         we1_i,
	input  wire ram_addr_t addr1_i,
	input  wire acc_t   wdata1_i,
	output logic        gnt1_o,
	output logic        ram_we_o,
	output ram_addr_t   ram_addr_o,
	output acc_t        ram_wdata_o
);

	// clear sweep state
	logic clr_active;
	ram_addr_t clr_addr;
	// 1 when requester 1 won last, gives 0 priority next time
	logic last_gnt1;

	// ------------------------------
	// clear sweep, one word per cycle
	always_ff @(posedge clock)
	begin
		if (rst_i)
		begin
			clr_active <= 1'b1;
			clr_addr <= '0;
		end
		else if (clr_active)
		begin
			clr_addr <= clr_addr + 1'b1;
			if (clr_addr == ram_addr_t'(RAM_DEPTH - 1))
				clr_active <= 1'b0;
		end
	end

	// ------------------------------
	// grant logic
	// no grants while clearing
	assign gnt0_o = ~clr_active & req0_i & (~req1_i | last_gnt1);
	assign gnt1_o = ~clr_active & req1_i & (~req0_i | ~last_gnt1);

	always_ff @(posedge clock)
	begin
		if (rst_i)
			last_gnt1 <= 1'b1;
		else if (gnt0_o)
			last_gnt1 <= 1'b0;
		else if (gnt1_o)
			last_gnt1 <= 1'b1;
	end

	// memory port mux, idle cycles read from requester 0's address
	always_comb
	begin
		if (clr_active)
		begin
			ram_we_o = 1'b1;
			ram_addr_o = clr_addr;
			ram_wdata_o = '0;
		end
		else if (gnt1_o)
		begin
			ram_we_o = we1_i;
			ram_addr_o = addr1_i;
			ram_wdata_o = wdata1_i;
		end
		else
		begin
			ram_we_o = gnt0_o & we0_i;
			ram_addr_o = addr0_i;
			ram_wdata_o = wdata0_i;
		end
	end

endmodule

`default_nettype wire

/* vlog.f */
logic/cic_pkg.sv
logic/comb_ram.sv
logic/comb_ram_arbiter.sv
logic/cic_integrator_chain.sv
logic/cic_comb_sequencer.sv
logic/cic_rx_top.sv
bench/tb_clock_gen.sv
bench/tb_cic_rx.sv
